//--- sources.f
+incdir+test
rtl/sm83_pkg.sv
rtl/alu.sv
rtl/register_file.sv
rtl/control_unit.sv
rtl/sm83_core.sv
test/sm83_core_assert.sv
test/tb_sm83_core.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_sm83_core -f sources.f
out=$(./obj_dir/Vtb_sm83_core)
echo "$out"

if echo "$out" | grep -qx "NO ERRORS"; then
  exit 0
fi
exit 1

//--- test/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

localparam int NUM_ROWS = 12;
localparam int MAX_PROG = 32;
localparam int MAX_WR   = 4;
localparam int MAX_PRE  = 2;

logic [7:0]      prog       [NUM_ROWS][MAX_PROG];
int              prog_len   [NUM_ROWS];
sm83_pkg::addr_t pre_addr   [NUM_ROWS][MAX_PRE];
sm83_pkg::data_t pre_data   [NUM_ROWS][MAX_PRE];
int              pre_count  [NUM_ROWS];
sm83_pkg::addr_t exp_addr   [NUM_ROWS][MAX_WR];
sm83_pkg::data_t exp_data   [NUM_ROWS][MAX_WR];
int              exp_count  [NUM_ROWS];
int              row_cycles [NUM_ROWS];
string           row_name   [NUM_ROWS];

task automatic add_byte(input int row, input logic [7:0] b);
  prog[row][prog_len[row]] = b;
  prog_len[row]++;
endtask

task automatic add_preload(input int row, input sm83_pkg::addr_t a, input sm83_pkg::data_t d);
  pre_addr[row][pre_count[row]] = a;
  pre_data[row][pre_count[row]] = d;
  pre_count[row]++;
endtask

task automatic add_expected_write(input int row, input sm83_pkg::addr_t a,
                                  input sm83_pkg::data_t d);
  exp_addr[row][exp_count[row]] = a;
  exp_data[row][exp_count[row]] = d;
  exp_count[row]++;
endtask

task automatic add_bytes2(input int row, input logic [7:0] b0, input logic [7:0] b1);
  add_byte(row, b0);
  add_byte(row, b1);
endtask

task automatic build_table();
  int r;
  logic [8:0] res;
  logic c;
  logic [7:0] a1, b1, n1, m1, a2, a3;
  for (int i = 0; i < NUM_ROWS; i++) begin
    prog_len[i]  = 0;
    pre_count[i] = 0;
    exp_count[i] = 0;
    for (int j = 0; j < MAX_PROG; j++) begin
      prog[i][j] = 8'h00;
    end
  end

  // LD H,n / LD L,n / LD B,n / LD C,B / LD [HL],C
  row_name[0] = "loads";
  add_bytes2(0, 8'h26, 8'h80);
  add_bytes2(0, 8'h2E, 8'h10);
  add_bytes2(0, 8'h06, 8'h5A);
  add_byte(0, 8'h48);
  add_byte(0, 8'h71);
  add_expected_write(0, 16'h8010, 8'h5A);
  row_cycles[0] = 9;

  // LD D,[HL] / LD [HL],n / LD [HL],D
  row_name[1] = "memory copy";
  add_preload(1, 16'h8020, 8'hC3);
  add_bytes2(1, 8'h26, 8'h80);
  add_bytes2(1, 8'h2E, 8'h20);
  add_byte(1, 8'h56);
  add_bytes2(1, 8'h36, 8'h99);
  add_bytes2(1, 8'h2E, 8'h21);
  add_byte(1, 8'h72);
  add_expected_write(1, 16'h8020, 8'h99);
  add_expected_write(1, 16'h8021, 8'hC3);
  row_cycles[1] = 13;

  // F0+20 carries into ADC; INC B keeps the carry of ADD A,A
  row_name[2] = "carry";
  add_bytes2(2, 8'h3E, 8'hF0);
  add_bytes2(2, 8'h06, 8'h20);
  add_byte(2, 8'h80);
  add_bytes2(2, 8'h06, 8'h00);
  add_byte(2, 8'h88);
  add_bytes2(2, 8'h26, 8'hA0);
  add_bytes2(2, 8'h2E, 8'h00);
  add_byte(2, 8'h77);
  add_bytes2(2, 8'h3E, 8'hFF);
  add_byte(2, 8'h87);
  add_byte(2, 8'h04);
  add_byte(2, 8'h88);
  add_bytes2(2, 8'h2E, 8'h01);
  add_byte(2, 8'h77);
  add_byte(2, 8'h88);
  add_bytes2(2, 8'h2E, 8'h02);
  add_byte(2, 8'h77);
  add_expected_write(2, 16'hA000, 8'h11);
  add_expected_write(2, 16'hA001, 8'h00);
  add_expected_write(2, 16'hA002, 8'h02);
  row_cycles[2] = 28;

  row_name[3] = "inc/dec [HL]";
  add_preload(3, 16'hB000, 8'hFF);
  add_preload(3, 16'hB001, 8'h10);
  add_bytes2(3, 8'h26, 8'hB0);
  add_bytes2(3, 8'h2E, 8'h00);
  add_byte(3, 8'h34);
  add_bytes2(3, 8'h2E, 8'h01);
  add_byte(3, 8'h35);
  add_expected_write(3, 16'hB000, 8'h00);
  add_expected_write(3, 16'hB001, 8'h0F);
  row_cycles[3] = 12;

  // One row per ALU op: register, immediate and [HL] operand
  for (int k = 0; k < 8; k++) begin
    r = 4 + k;
    row_name[r] = $sformatf("alu op %0d", k);
    rng = xorshift(rng);
    a1  = rng[7:0];
    b1  = rng[15:8];
    n1  = rng[23:16];
    m1  = rng[31:24];
    rng = xorshift(rng);
    a2  = rng[7:0];
    a3  = rng[15:8];
    c   = 1'b0;

    add_bytes2(r, 8'h3E, a1);
    add_bytes2(r, 8'h06, b1);
    add_byte(r, 8'h80 + 8'(k * 8));
    res = alu_expect(k, a1, b1, c);
    c   = res[8];
    add_bytes2(r, 8'h26, 8'h90);
    add_bytes2(r, 8'h2E, 8'h00);
    add_byte(r, 8'h77);
    add_expected_write(r, 16'h9000, res[7:0]);

    add_bytes2(r, 8'h3E, a2);
    add_bytes2(r, 8'hC6 + 8'(k * 8), n1);
    res = alu_expect(k, a2, n1, c);
    c   = res[8];
    add_byte(r, 8'h77);
    add_expected_write(r, 16'h9000, res[7:0]);

    add_preload(r, 16'h9001, m1);
    add_bytes2(r, 8'h2E, 8'h01);
    add_bytes2(r, 8'h3E, a3);
    add_byte(r, 8'h86 + 8'(k * 8));
    res = alu_expect(k, a3, m1, c);
    add_bytes2(r, 8'h2E, 8'h02);
    add_byte(r, 8'h77);
    add_expected_write(r, 16'h9002, res[7:0]);
    row_cycles[r] = 27;
  end
endtask

`endif

//--- test/tb_sm83_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sm83_core;

  logic            clk = 1'b0;
  logic            rst;
  sm83_pkg::addr_t mem_addr;
  logic            mem_rd;
  logic            mem_wr;
  sm83_pkg::data_t mem_wdata;
  sm83_pkg::data_t mem_rdata;

  logic [7:0]      mem [0:65535];
  int              errors = 0;
  int              passed = 0;
  int              wr_idx = 0;
  int              cur_row = 0;
  logic            fetch_seen = 1'b0;
  sm83_pkg::addr_t last_pc_addr;
  logic [31:0]     rng;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // {carry, result} of one ALU operation; CP keeps A and reports the borrow
  function automatic logic [8:0] alu_expect(input int op, input logic [7:0] a,
                                            input logic [7:0] b, input logic cin);
    logic [8:0] r;
    case (op)
      0:       r = {1'b0, a} + {1'b0, b};
      1:       r = {1'b0, a} + {1'b0, b} + {8'd0, cin};
      2:       r = {1'b0, a} - {1'b0, b};
      3:       r = {1'b0, a} - {1'b0, b} - {8'd0, cin};
      4:       r = {1'b0, a & b};
      5:       r = {1'b0, a ^ b};
      6:       r = {1'b0, a | b};
      default: begin
        r = {1'b0, a} - {1'b0, b};
        r = {r[8], a};
      end
    endcase
    return r;
  endfunction

  `include "tb_programs.svh"

  sm83_core DUT (
    .clk       (clk),
    .rst       (rst),
    .mem_addr  (mem_addr),
    .mem_rd    (mem_rd),
    .mem_wr    (mem_wr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

  always #10 clk = ~clk;

  // Memory answers a read in the same cycle and floats high otherwise
  assign mem_rdata = mem_rd ? mem[mem_addr] : 8'hFF;

  task automatic check_addr(input sm83_pkg::addr_t got, input sm83_pkg::addr_t exp,
                            input string what);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_data(input sm83_pkg::data_t got, input sm83_pkg::data_t exp,
                            input string what);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  // Bus monitor, sampled mid-cycle
  always @(negedge clk) begin
    if (rst) begin
      fetch_seen = 1'b0;
    end else begin
      if (mem_wr) begin
        if (wr_idx < exp_count[cur_row]) begin
          check_addr(mem_addr, exp_addr[cur_row][wr_idx], "write address");
          check_data(mem_wdata, exp_data[cur_row][wr_idx], "write data");
        end else begin
          errors++;
          $display("Unexpected extra write of %h to %h at %0t ns", mem_wdata, mem_addr, $time);
        end
        mem[mem_addr] = mem_wdata;
        wr_idx++;
      end
      // Program space only as [HL] targets sit far above it
      if (mem_rd && (mem_addr < 16'h0100)) begin
        if (!fetch_seen) begin
          check_addr(mem_addr, sm83_pkg::RESET_PC, "first fetch after reset");
        end else begin
          check_addr(mem_addr, last_pc_addr + 16'd1, "next PC address");
        end
        fetch_seen   = 1'b1;
        last_pc_addr = mem_addr;
      end
    end
  end

  task automatic run_row(input int row);
    int cycles;
    int limit;
    int err_before;
    err_before = errors;
    limit      = 2 * row_cycles[row] + 20;
    @(posedge clk);
    #1;
    rst = 1'b1;
    // Zeros are NOPs, so the program runs into a NOP loop
    for (int a = 0; a < 256; a++) begin
      mem[a] = 8'h00;
    end
    for (int i = 0; i < prog_len[row]; i++) begin
      mem[i] = prog[row][i];
    end
    for (int i = 0; i < pre_count[row]; i++) begin
      mem[pre_addr[row][i]] = pre_data[row][i];
    end
    cur_row = row;
    wr_idx  = 0;
    repeat (10) @(posedge clk);
    #1;
    rst    = 1'b0;
    cycles = 0;
    while ((wr_idx < exp_count[row]) && (cycles < limit)) begin
      @(posedge clk);
      cycles++;
    end
    if (wr_idx < exp_count[row]) begin
      errors++;
      $display("Timeout: row %0d (%s) saw %0d of %0d writes in %0d cycles",
               row, row_name[row], wr_idx, exp_count[row], limit);
    end
    if (errors == err_before) begin
      passed++;
      $display("Row %0d %s: pass", row, row_name[row]);
    end else begin
      $display("Row %0d %s: FAIL", row, row_name[row]);
    end
  endtask

  initial begin
    rst = 1'b1;
    rng = 32'hb36e;
    for (int i = 0; i < 65536; i++) begin
      mem[i] = 8'(i[15:8] ^ i[7:0] ^ 8'h5A);
    end
    build_table();
    for (int row = 0; row < NUM_ROWS; row++) begin
      run_row(row);
    end
    $display("Rows: %0d, passed: %0d, errors: %0d", NUM_ROWS, passed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/sm83_core_assert.sv
`timescale 1ns/1ps
`default_nettype none

module sm83_core_assert (
  input logic                clk,
  input logic                rst,
  input logic                mem_rd,
  input logic                mem_wr,
  input sm83_pkg::addr_t     mem_addr,
  input sm83_pkg::bus_op_t   bus_op,
  input sm83_pkg::addr_sel_t addr_sel
);

  // Exactly one strobe in every cycle as the core never idles the bus
  assert property (@(posedge clk) disable iff (rst) (mem_rd != mem_wr))
    else $error("mem_rd and mem_wr not exactly one high");

  assert property (@(posedge clk) $fell(rst) |-> !mem_wr)
    else $error("mem_wr high in the first cycle after reset");

  // PC side accesses advance by one; [HL] cycles are exempt
  assert property (@(posedge clk) disable iff (rst)
      (bus_op == sm83_pkg::BUS_FETCH) |=>
      ((addr_sel == sm83_pkg::ADDR_HL) || (mem_addr == 16'($past(mem_addr) + 16'd1))))
    else $error("PC address did not advance after a fetch");

endmodule

bind sm83_core sm83_core_assert u_core_assert (
  .clk      (clk),
  .rst      (rst),
  .mem_rd   (mem_rd),
  .mem_wr   (mem_wr),
  .mem_addr (mem_addr),
  .bus_op   (bus_op),
  .addr_sel (addr_sel)
);

`default_nettype wire

//--- rtl/sm83_core.sv
`timescale 1ns/1ps
`default_nettype none

module sm83_core (
  input  logic            clk,
  input  logic            rst,
  output sm83_pkg::addr_t mem_addr,
  output logic            mem_rd,
  output logic            mem_wr,
  output sm83_pkg::data_t mem_wdata,
  input  sm83_pkg::data_t mem_rdata
);

  sm83_pkg::bus_op_t    bus_op;
  sm83_pkg::addr_sel_t  addr_sel;
  logic                 pc_inc;
  sm83_pkg::reg_sel_t   rd_sel;
  sm83_pkg::reg_sel_t   wr_sel;
  logic                 wr_en;
  logic                 wr_from_bus;
  logic                 flags_we;
  sm83_pkg::flags_t     flags_mask;
  sm83_pkg::alu_op_t    alu_op;
  sm83_pkg::alu_src_a_t src_a;
  sm83_pkg::alu_src_b_t src_b;
  sm83_pkg::dout_sel_t  dout_sel;
  sm83_pkg::data_t      rd_data;
  sm83_pkg::data_t      acc;
  sm83_pkg::flags_t     flags;
  sm83_pkg::data_t      alu_result;
  sm83_pkg::flags_t     alu_flags;

  control_unit u_control_unit (
    .clk         (clk),
    .rst         (rst),
    .fetch_byte  (mem_rdata),
    .bus_op      (bus_op),
    .addr_sel    (addr_sel),
    .pc_inc      (pc_inc),
    .rd_sel      (rd_sel),
    .wr_sel      (wr_sel),
    .wr_en       (wr_en),
    .wr_from_bus (wr_from_bus),
    .flags_we    (flags_we),
    .flags_mask  (flags_mask),
    .alu_op      (alu_op),
    .src_a       (src_a),
    .src_b       (src_b),
    .dout_sel    (dout_sel)
  );

  register_file u_register_file (
    .clk         (clk),
    .rst         (rst),
    .rd_sel      (rd_sel),
    .wr_sel      (wr_sel),
    .wr_en       (wr_en),
    .wr_from_bus (wr_from_bus),
    .bus_data    (mem_rdata),
    .alu_result  (alu_result),
    .flags_we    (flags_we),
    .flags_mask  (flags_mask),
    .alu_flags   (alu_flags),
    .addr_sel    (addr_sel),
    .pc_inc      (pc_inc),
    .rd_data     (rd_data),
    .acc         (acc),
    .flags       (flags),
    .addr        (mem_addr)
  );

  alu u_alu (
    .op        (alu_op),
    .src_a     (src_a),
    .src_b     (src_b),
    .reg_data  (rd_data),
    .acc       (acc),
    .flags_in  (flags),
    .result    (alu_result),
    .flags_out (alu_flags)
  );

  // Bus strobes
  assign mem_rd = (bus_op == sm83_pkg::BUS_FETCH) || (bus_op == sm83_pkg::BUS_READ);
  assign mem_wr = (bus_op == sm83_pkg::BUS_WRITE);

  // Stores take a register byte, INC/DEC [HL] takes the ALU result
  assign mem_wdata = (dout_sel == sm83_pkg::DOUT_ALU) ? alu_result : rd_data;

endmodule

`default_nettype wire

//--- rtl/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  sm83_pkg::data_t      fetch_byte,
  output sm83_pkg::bus_op_t    bus_op,
  output sm83_pkg::addr_sel_t  addr_sel,
  output logic                 pc_inc,
  output sm83_pkg::reg_sel_t   rd_sel,
  output sm83_pkg::reg_sel_t   wr_sel,
  output logic                 wr_en,
  output logic                 wr_from_bus,
  output logic                 flags_we,
  output sm83_pkg::flags_t     flags_mask,
  output sm83_pkg::alu_op_t    alu_op,
  output sm83_pkg::alu_src_a_t src_a,
  output sm83_pkg::alu_src_b_t src_b,
  output sm83_pkg::dout_sel_t  dout_sel
);

  sm83_pkg::data_t               ir;
  logic [sm83_pkg::MCYCLE_W-1:0] mcycle;
  logic [sm83_pkg::MCYCLE_W-1:0] exec_cycle;

  logic [1:0] grp;
  logic [2:0] dst;
  logic [2:0] src;

  logic is_ld_imm;
  logic is_incdec;
  logic is_ld_rr;
  logic is_alu_r;
  logic is_alu_n;
  logic imm_read;
  logic hl_read;
  logic pre_read;
  logic mem_dst;

  sm83_pkg::reg_sel_t operand;

  assign grp = ir[7:6];
  assign dst = ir[5:3];
  assign src = ir[2:0];

  // Opcode groups
  assign is_ld_imm = (grp == sm83_pkg::GRP_MISC) && (src == sm83_pkg::FIELD_MEM);
  assign is_incdec = (grp == sm83_pkg::GRP_MISC) && (src[2:1] == 2'b10);
  assign is_ld_rr  = (grp == sm83_pkg::GRP_LD_RR);
  assign is_alu_r  = (grp == sm83_pkg::GRP_ALU_R);
  assign is_alu_n  = (grp == sm83_pkg::GRP_ALU_N) && (src == sm83_pkg::FIELD_MEM);

  // Operand first read into Z, either from PC or from [HL]
  assign imm_read = is_ld_imm || is_alu_n;
  assign hl_read  = (is_incdec && (dst == sm83_pkg::FIELD_MEM)) ||
                    ((is_ld_rr || is_alu_r) && (src == sm83_pkg::FIELD_MEM));
  assign pre_read = imm_read || hl_read;

  // Result goes back to [HL] in a separate write cycle
  assign mem_dst = (is_ld_imm || is_ld_rr || is_incdec) && (dst == sm83_pkg::FIELD_MEM);

  // Execute cycle follows the operand read, if there is one
  assign exec_cycle = {{(sm83_pkg::MCYCLE_W-1){1'b0}}, pre_read};
  assign operand    = pre_read ? sm83_pkg::REG_Z : sm83_pkg::reg_sel_t'(src);

  always_ff @(posedge clk) begin
    if (rst) begin
      ir     <= sm83_pkg::OPC_NOP;
      mcycle <= '0;
    end else if (bus_op == sm83_pkg::BUS_FETCH) begin
      ir     <= fetch_byte;
      mcycle <= '0;
    end else begin
      mcycle <= mcycle + 1'b1;
    end
  end

  always_comb begin
    // Default cycle is the opcode fetch, which also ends every instruction
    bus_op      = sm83_pkg::BUS_FETCH;
    addr_sel    = sm83_pkg::ADDR_PC;
    pc_inc      = 1'b1;
    rd_sel      = sm83_pkg::REG_A;
    wr_sel      = sm83_pkg::REG_A;
    wr_en       = 1'b0;
    wr_from_bus = 1'b0;
    flags_we    = 1'b0;
    flags_mask  = '0;
    alu_op      = sm83_pkg::ALU_ADD;
    src_a       = sm83_pkg::SRC_A_REG;
    src_b       = sm83_pkg::SRC_B_ZERO;
    dout_sel    = sm83_pkg::DOUT_REG;

    if (pre_read && (mcycle == '0)) begin
      // Operand byte into Z
      bus_op      = sm83_pkg::BUS_READ;
      addr_sel    = imm_read ? sm83_pkg::ADDR_PC : sm83_pkg::ADDR_HL;
      pc_inc      = imm_read;
      wr_sel      = sm83_pkg::REG_Z;
      wr_en       = 1'b1;
      wr_from_bus = 1'b1;
    end else if (mcycle == exec_cycle) begin
      if (is_ld_imm || is_ld_rr) begin
        rd_sel = operand;
        if (mem_dst) begin
          bus_op   = sm83_pkg::BUS_WRITE;
          addr_sel = sm83_pkg::ADDR_HL;
          pc_inc   = 1'b0;
          dout_sel = sm83_pkg::DOUT_REG;
        end else begin
          // Copy through the ALU as an add of zero
          wr_sel = sm83_pkg::reg_sel_t'(dst);
          wr_en  = 1'b1;
        end
      end else if (is_incdec) begin
        rd_sel     = mem_dst ? sm83_pkg::REG_Z : sm83_pkg::reg_sel_t'(dst);
        alu_op     = ir[0] ? sm83_pkg::ALU_SUB : sm83_pkg::ALU_ADD;
        src_b      = sm83_pkg::SRC_B_ONE;
        flags_we   = 1'b1;
        // Carry is left untouched
        flags_mask = '{z: 1'b1, n: 1'b1, h: 1'b1, c: 1'b0};
        if (mem_dst) begin
          bus_op   = sm83_pkg::BUS_WRITE;
          addr_sel = sm83_pkg::ADDR_HL;
          pc_inc   = 1'b0;
          dout_sel = sm83_pkg::DOUT_ALU;
        end else begin
          wr_sel = sm83_pkg::reg_sel_t'(dst);
          wr_en  = 1'b1;
        end
      end else if (is_alu_r || is_alu_n) begin
        rd_sel     = operand;
        alu_op     = sm83_pkg::alu_op_t'(dst);
        src_a      = sm83_pkg::SRC_A_ACC;
        src_b      = sm83_pkg::SRC_B_REG;
        // CP only updates the flags
        wr_en      = (dst != sm83_pkg::OP_CP);
        wr_sel     = sm83_pkg::REG_A;
        flags_we   = 1'b1;
        flags_mask = '1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic                clk,
  input  logic                rst,
  input  sm83_pkg::reg_sel_t  rd_sel,
  input  sm83_pkg::reg_sel_t  wr_sel,
  input  logic                wr_en,
  input  logic                wr_from_bus,
  input  sm83_pkg::data_t     bus_data,
  input  sm83_pkg::data_t     alu_result,
  input  logic                flags_we,
  input  sm83_pkg::flags_t    flags_mask,
  input  sm83_pkg::flags_t    alu_flags,
  input  sm83_pkg::addr_sel_t addr_sel,
  input  logic                pc_inc,
  output sm83_pkg::data_t     rd_data,
  output sm83_pkg::data_t     acc,
  output sm83_pkg::flags_t    flags,
  output sm83_pkg::addr_t     addr
);

  // B C D E H L Z A, indexed by reg_sel_t
  sm83_pkg::data_t regs [0:7];
  sm83_pkg::addr_t pc;
  sm83_pkg::data_t wr_data;

  // Write port merges the bus byte and the ALU result
  assign wr_data = wr_from_bus ? bus_data : alu_result;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
      flags <= '0;
      pc    <= sm83_pkg::RESET_PC;
    end else begin
      if (wr_en) begin
        regs[wr_sel] <= wr_data;
      end
      // Only masked flag bits change
      if (flags_we) begin
        flags <= sm83_pkg::flags_t'((flags & ~flags_mask) | (alu_flags & flags_mask));
      end
      if (pc_inc) begin
        pc <= pc + 16'd1;
      end
    end
  end

  assign rd_data = regs[rd_sel];
  assign acc     = regs[sm83_pkg::REG_A];

  // Bus address is PC or the H:L pair
  assign addr = (addr_sel == sm83_pkg::ADDR_HL) ?
                {regs[sm83_pkg::REG_H], regs[sm83_pkg::REG_L]} : pc;

endmodule

`default_nettype wire

//--- rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  sm83_pkg::alu_op_t    op,
  input  sm83_pkg::alu_src_a_t src_a,
  input  sm83_pkg::alu_src_b_t src_b,
  input  sm83_pkg::data_t      reg_data,
  input  sm83_pkg::data_t      acc,
  input  sm83_pkg::flags_t     flags_in,
  output sm83_pkg::data_t      result,
  output sm83_pkg::flags_t     flags_out
);

  sm83_pkg::data_t a;
  sm83_pkg::data_t b;
  logic            cin;
  logic [4:0]      half_sum;
  logic [4:0]      half_diff;
  logic [8:0]      full_sum;
  logic [8:0]      full_diff;

  // Operand selection
  always_comb begin
    a = (src_a == sm83_pkg::SRC_A_ACC) ? acc : reg_data;
    case (src_b)
      sm83_pkg::SRC_B_REG:  b = reg_data;
      sm83_pkg::SRC_B_ONE:  b = 8'h01;
      sm83_pkg::SRC_B_ZERO: b = 8'h00;
      default:              b = 8'h00;
    endcase
  end

  // Carry in only for ADC and SBC
  assign cin = ((op == sm83_pkg::ALU_ADC) || (op == sm83_pkg::ALU_SBC)) ? flags_in.c : 1'b0;

  // Bit 4 of the nibble sums gives the half carry or borrow
  assign half_sum  = {1'b0, a[3:0]} + {1'b0, b[3:0]} + 5'(cin);
  assign half_diff = {1'b0, a[3:0]} - {1'b0, b[3:0]} - 5'(cin);
  assign full_sum  = {1'b0, a} + {1'b0, b} + 9'(cin);
  assign full_diff = {1'b0, a} - {1'b0, b} - 9'(cin);

  always_comb begin
    result    = full_sum[7:0];
    flags_out = '0;
    case (op)
      sm83_pkg::ALU_ADD, sm83_pkg::ALU_ADC: begin
        result      = full_sum[7:0];
        flags_out.h = half_sum[4];
        flags_out.c = full_sum[8];
      end
      // CP computes a subtract, the result is simply not stored
      sm83_pkg::ALU_SUB, sm83_pkg::ALU_SBC, sm83_pkg::ALU_CP: begin
        result      = full_diff[7:0];
        flags_out.n = 1'b1;
        flags_out.h = half_diff[4];
        flags_out.c = full_diff[8];
      end
      sm83_pkg::ALU_AND: begin
        result      = a & b;
        flags_out.h = 1'b1;
      end
      sm83_pkg::ALU_XOR: begin
        result = a ^ b;
      end
      sm83_pkg::ALU_OR: begin
        result = a | b;
      end
      default: begin
        result = full_sum[7:0];
      end
    endcase
    flags_out.z = (result == 8'h00);
  end

endmodule

`default_nettype wire

//--- rtl/sm83_pkg.sv
`default_nettype none

package sm83_pkg;

  // Datapath widths
  typedef logic [7:0]  data_t;
  typedef logic [15:0] addr_t;

  // Codes equal the 3-bit register field of the opcode
  // Slot 6 is [HL] in the opcode and holds Z inside the core
  typedef enum logic [2:0] {
    REG_B = 3'd0,
    REG_C = 3'd1,
    REG_D = 3'd2,
    REG_E = 3'd3,
    REG_H = 3'd4,
    REG_L = 3'd5,
    REG_Z = 3'd6,
    REG_A = 3'd7
  } reg_sel_t;

  // Same order as bits 5:3 of the ALU opcodes
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_ADC = 3'd1,
    ALU_SUB = 3'd2,
    ALU_SBC = 3'd3,
    ALU_AND = 3'd4,
    ALU_XOR = 3'd5,
    ALU_OR  = 3'd6,
    ALU_CP  = 3'd7
  } alu_op_t;

  typedef enum logic {
    SRC_A_REG,
    SRC_A_ACC
  } alu_src_a_t;

  typedef enum logic [1:0] {
    SRC_B_REG,
    SRC_B_ZERO,
    SRC_B_ONE
  } alu_src_b_t;

  // Flag group, also serves as the per-bit write mask
  typedef struct packed {
    logic z;
    logic n;
    logic h;
    logic c;
  } flags_t;

  typedef enum logic [1:0] {
    BUS_IDLE,
    BUS_FETCH,
    BUS_READ,
    BUS_WRITE
  } bus_op_t;

  typedef enum logic {
    ADDR_PC,
    ADDR_HL
  } addr_sel_t;

  typedef enum logic {
    DOUT_REG,
    DOUT_ALU
  } dout_sel_t;

  localparam int MCYCLE_W = 2;

  // Opcode fields
  localparam logic [2:0] FIELD_MEM = 3'd6;
  localparam logic [2:0] OP_CP     = 3'd7;
  localparam data_t      OPC_NOP   = 8'h00;

  // Top two opcode bits select the instruction group
  localparam logic [1:0] GRP_MISC  = 2'b00;
  localparam logic [1:0] GRP_LD_RR = 2'b01;
  localparam logic [1:0] GRP_ALU_R = 2'b10;
  localparam logic [1:0] GRP_ALU_N = 2'b11;

  localparam addr_t RESET_PC = 16'h0000;

endpackage

`default_nettype wire
